//--- hw/sysctl_pkg.sv
// shared types and constants for the system-control block
// covers the PI1 bus types, the address map, device ids and reset sizes
// every file refers to these by scoped name

package sysctl_pkg;

	localparam int ARCH_BITS = 32;

	typedef logic [ARCH_BITS-1:0] arch_word_t;
	// word address, byte address without its two low bits
	typedef logic [ARCH_BITS-3:0] pi1_addr_t;
	typedef logic [ARCH_BITS/8-1:0] byte_sel_t;

	typedef enum logic [1:0] {
		OP_NOP   = 2'd0,
		OP_WRITE = 2'd1,
		OP_READ  = 2'd2
	} pi1_op_e;

	typedef struct packed {
		pi1_op_e    op;
		pi1_addr_t  addr;
		arch_word_t data;
		byte_sel_t  sel;
	} pi1_req_t;

	typedef struct packed {
		arch_word_t data;
		logic       rdy;
	} pi1_rsp_t;

	// slave indices in address order, the last one catches unmapped space
	typedef enum logic [1:0] {
		SLV_DEVTBL  = 2'd0,
		SLV_SCRATCH = 2'd1,
		SLV_INVALID = 2'd2
	} slave_sel_e;

	localparam arch_word_t SLAVE_COUNT = 32'd3;

	// map sizes in bytes
	localparam arch_word_t DEVTBL_MAPSZ  = 32'd256;
	localparam arch_word_t SCRATCH_MAPSZ = 32'd1024;
	localparam arch_word_t INVALID_MAPSZ = 32'h0000_1000;

	localparam arch_word_t DEVTBL_BASE  = 32'd0;
	localparam arch_word_t SCRATCH_BASE = DEVTBL_BASE + DEVTBL_MAPSZ;

	localparam int SCRATCH_WORDS = 256;

	localparam arch_word_t SOC_ID        = 32'd1;
	localparam arch_word_t DEVID_DEVTBL  = 32'd7;
	localparam arch_word_t DEVID_RAM     = 32'd1;
	localparam arch_word_t DEVID_INVALID = 32'd0;

	// one bit per slave, none of them raise interrupts here
	localparam logic [2:0] USEINTR_MASK = 3'b000;

	typedef struct packed {
		logic rst0;
		logic rst1;
		logic valid;
	} rst_ctl_t;

	localparam int RST_CNT_BITS = 4;
	typedef logic [RST_CNT_BITS-1:0] rst_cnt_t;

endpackage

//--- hw/pi1_addr_decoder.sv
// PI1 address decoder for the single bus master
// picks one slave from the package address map and muxes its response
// unmapped addresses are answered here with zero data and immediate rdy

`timescale 1ns/1ps

module pi1_addr_decoder (
	input  logic                clk120mhz,
	input  logic                rst_p,
	input  sysctl_pkg::pi1_req_t m_req_i,
	output sysctl_pkg::pi1_rsp_t m_rsp_o,
	output sysctl_pkg::pi1_req_t devtbl_req_o,
	output sysctl_pkg::pi1_req_t scratch_req_o,
	input  sysctl_pkg::pi1_rsp_t devtbl_rsp_i,
	input  sysctl_pkg::pi1_rsp_t scratch_rsp_i
);

	sysctl_pkg::arch_word_t byte_addr;
	sysctl_pkg::slave_sel_e slv_sel;
	logic                   inv_active;

	assign byte_addr = {m_req_i.addr, 2'b00};

	// unsigned offset compare also rejects addresses below the base
	always_comb begin
		if ((byte_addr - sysctl_pkg::DEVTBL_BASE) < sysctl_pkg::DEVTBL_MAPSZ) begin
			slv_sel = sysctl_pkg::SLV_DEVTBL;
		end else if ((byte_addr - sysctl_pkg::SCRATCH_BASE) < sysctl_pkg::SCRATCH_MAPSZ) begin
			slv_sel = sysctl_pkg::SLV_SCRATCH;
		end else begin
			slv_sel = sysctl_pkg::SLV_INVALID;
		end
	end

	assign inv_active = (slv_sel == sysctl_pkg::SLV_INVALID) &&
		(m_req_i.op != sysctl_pkg::OP_NOP);

	// slaves see their own word offset, and a NOP unless addressed
	always_comb begin
		devtbl_req_o = m_req_i;
		devtbl_req_o.addr = m_req_i.addr -
			sysctl_pkg::pi1_addr_t'(sysctl_pkg::DEVTBL_BASE >> 2);
		if (slv_sel != sysctl_pkg::SLV_DEVTBL) begin
			devtbl_req_o.op = sysctl_pkg::OP_NOP;
		end

		scratch_req_o = m_req_i;
		scratch_req_o.addr = m_req_i.addr -
			sysctl_pkg::pi1_addr_t'(sysctl_pkg::SCRATCH_BASE >> 2);
		if (slv_sel != sysctl_pkg::SLV_SCRATCH) begin
			scratch_req_o.op = sysctl_pkg::OP_NOP;
		end
	end

	// default responder drops writes and reads back zero
	always_comb begin
		case (slv_sel)
			sysctl_pkg::SLV_DEVTBL:  m_rsp_o = devtbl_rsp_i;
			sysctl_pkg::SLV_SCRATCH: m_rsp_o = scratch_rsp_i;
			default:                 m_rsp_o = '{data: '0, rdy: inv_active};
		endcase
	end

	a_one_slave: assert property (@(posedge clk120mhz) disable iff (rst_p)
		$onehot0({devtbl_req_o.op != sysctl_pkg::OP_NOP,
			scratch_req_o.op != sysctl_pkg::OP_NOP, inv_active}));

	// a slave must never complete a request the master is not holding
	a_rdy_needs_op: assert property (@(posedge clk120mhz) disable iff (rst_p)
		m_rsp_o.rdy |-> (m_req_i.op != sysctl_pkg::OP_NOP));

endmodule

//--- hw/dev_table_regs.sv
// device table and reset-control register on the PI1 bus
// software walks the table to find each slave's id and map size
// a write to word 0 requests a cold, warm or power-off reset

`timescale 1ns/1ps

module dev_table_regs (
	input  logic                 clk120mhz,
	input  logic                 rst_p,
	input  sysctl_pkg::pi1_req_t req_i,
	output sysctl_pkg::pi1_rsp_t rsp_o,
	output sysctl_pkg::rst_ctl_t rst_ctl_o
);

	logic                   rdy_q;
	sysctl_pkg::arch_word_t rd_data_q;
	sysctl_pkg::arch_word_t rd_word;
	sysctl_pkg::pi1_addr_t  entry;
	sysctl_pkg::arch_word_t entry_idx;
	sysctl_pkg::slave_sel_e entry_slv;
	logic                   take;
	logic                   rst_write;

	// entries start at word 2, two words per slave
	assign entry     = req_i.addr - sysctl_pkg::pi1_addr_t'(2);
	assign entry_idx = {3'b000, entry[29:1]};
	assign entry_slv = sysctl_pkg::slave_sel_e'(entry[2:1]);

	always_comb begin
		rd_word = '0;
		if (req_i.addr == '0) begin
			rd_word = sysctl_pkg::SOC_ID;
		end else if (req_i.addr == sysctl_pkg::pi1_addr_t'(1)) begin
			rd_word = sysctl_pkg::SLAVE_COUNT;
		end else if (entry_idx < sysctl_pkg::SLAVE_COUNT) begin
			if (!entry[0]) begin
				case (entry_slv)
					sysctl_pkg::SLV_DEVTBL:  rd_word = sysctl_pkg::DEVID_DEVTBL;
					sysctl_pkg::SLV_SCRATCH: rd_word = sysctl_pkg::DEVID_RAM;
					default:                 rd_word = sysctl_pkg::DEVID_INVALID;
				endcase
			end else begin
				case (entry_slv)
					sysctl_pkg::SLV_DEVTBL:  rd_word = sysctl_pkg::DEVTBL_MAPSZ;
					sysctl_pkg::SLV_SCRATCH: rd_word = sysctl_pkg::SCRATCH_MAPSZ;
					default:                 rd_word = sysctl_pkg::INVALID_MAPSZ;
				endcase
				// map sizes are powers of two, so bit 0 is free for the intr flag
				rd_word[0] = sysctl_pkg::USEINTR_MASK[entry_slv];
			end
		end
	end

	// rdy high means this request is done, so op is ignored for that cycle
	assign take = (req_i.op != sysctl_pkg::OP_NOP) && !rdy_q;
	assign rst_write = take && (req_i.op == sysctl_pkg::OP_WRITE) &&
		(req_i.addr == '0) && (req_i.data[1:0] != 2'b00);

	always_ff @(posedge clk120mhz) begin
		if (rst_p) begin
			rdy_q     <= 1'b0;
			rst_ctl_o <= '0;
		end else begin
			rdy_q     <= take;
			rst_ctl_o <= '0;
			if (rst_write) begin
				rst_ctl_o <= '{rst0: req_i.data[0], rst1: req_i.data[1], valid: 1'b1};
			end
		end
	end

	always_ff @(posedge clk120mhz) begin
		if (take) begin
			rd_data_q <= rd_word;
		end
	end

	assign rsp_o = '{data: rd_data_q, rdy: rdy_q};

	a_rdy_single: assert property (@(posedge clk120mhz) disable iff (rst_p)
		rdy_q |=> !rdy_q);

endmodule

//--- hw/reset_sequencer.sv
// system reset sequencer
// stretches every reset request to a fixed length, latches power-off
// until the next external reset and emits the cold-reset pulse

`timescale 1ns/1ps

module reset_sequencer (
	input  logic                 clk120mhz,
	input  logic                 rst_p,
	input  sysctl_pkg::rst_ctl_t rst_ctl_i,
	input  logic                 cpu_rst_req_i,
	output logic                 sys_rst_o,
	output logic                 coldrst_o,
	output logic                 pwroff_o
);

	sysctl_pkg::rst_cnt_t rst_cnt;
	logic                 cold_req;
	logic                 warm_req;
	logic                 pwroff_req;
	logic                 reload;

	// rst0 and rst1 together select cold, rst1 alone warm, rst0 alone power-off
	assign cold_req   = rst_ctl_i.valid && rst_ctl_i.rst0 && rst_ctl_i.rst1;
	assign warm_req   = rst_ctl_i.valid && !rst_ctl_i.rst0 && rst_ctl_i.rst1;
	assign pwroff_req = rst_ctl_i.valid && rst_ctl_i.rst0 && !rst_ctl_i.rst1;

	assign reload = rst_p || cpu_rst_req_i || warm_req;

	always_ff @(posedge clk120mhz) begin
		if (reload) begin
			rst_cnt <= '1;
		end else if (rst_cnt != '0) begin
			rst_cnt <= rst_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk120mhz) begin
		if (rst_p) begin
			pwroff_o  <= 1'b0;
			coldrst_o <= 1'b0;
		end else begin
			coldrst_o <= cold_req;
			if (pwroff_req) begin
				pwroff_o <= 1'b1;
			end
		end
	end

	// the request itself holds reset until the counter takes over
	assign sys_rst_o = reload || pwroff_o || (rst_cnt != '0);

	a_cold_pulse: assert property (@(posedge clk120mhz) disable iff (rst_p)
		coldrst_o |=> !coldrst_o);

endmodule

//--- hw/scratch_ram.sv
// scratch RAM slave on the PI1 bus
// word memory with per-byte write enables, one cycle to rdy

`timescale 1ns/1ps

module scratch_ram (
	input  logic                 clk120mhz,
	input  logic                 rst_p,
	input  sysctl_pkg::pi1_req_t req_i,
	output sysctl_pkg::pi1_rsp_t rsp_o
);

	sysctl_pkg::arch_word_t mem [sysctl_pkg::SCRATCH_WORDS];
	logic [$clog2(sysctl_pkg::SCRATCH_WORDS)-1:0] word_idx;
	logic                   rdy_q;
	sysctl_pkg::arch_word_t rd_data_q;
	logic                   take;

	assign word_idx = req_i.addr[$clog2(sysctl_pkg::SCRATCH_WORDS)-1:0];
	assign take     = (req_i.op != sysctl_pkg::OP_NOP) && !rdy_q;

	always_ff @(posedge clk120mhz) begin
		if (rst_p) begin
			rdy_q <= 1'b0;
		end else begin
			rdy_q <= take;
		end
	end

	always_ff @(posedge clk120mhz) begin
		if (take && req_i.op == sysctl_pkg::OP_WRITE) begin
			for (int lane = 0; lane < sysctl_pkg::ARCH_BITS / 8; lane++) begin
				if (req_i.sel[lane]) begin
					mem[word_idx][8*lane +: 8] <= req_i.data[8*lane +: 8];
				end
			end
		end
		if (take && req_i.op == sysctl_pkg::OP_READ) begin
			rd_data_q <= mem[word_idx];
		end
	end

	assign rsp_o = '{data: rd_data_q, rdy: rdy_q};

endmodule

//--- hw/sysctl_top.sv
// top level of the system-control block
// the bus master drives m_req_i, the slaves and reset logic sit behind it
// bus slaves run on rst_p so the bus stays usable during sys_rst_o

`timescale 1ns/1ps

module sysctl_top (
	input  logic                 clk120mhz,
	input  logic                 rst_p,
	input  sysctl_pkg::pi1_req_t m_req_i,
	output sysctl_pkg::pi1_rsp_t m_rsp_o,
	input  logic                 cpu_rst_req_i,
	output logic                 sys_rst_o,
	output logic                 coldrst_o,
	output logic                 pwroff_o
);

	sysctl_pkg::pi1_req_t devtbl_req;
	sysctl_pkg::pi1_rsp_t devtbl_rsp;
	sysctl_pkg::pi1_req_t scratch_req;
	sysctl_pkg::pi1_rsp_t scratch_rsp;
	sysctl_pkg::rst_ctl_t rst_ctl;

	pi1_addr_decoder pi1_addr_decoder_i (
		.clk120mhz     (clk120mhz),
		.rst_p         (rst_p),
		.m_req_i       (m_req_i),
		.m_rsp_o       (m_rsp_o),
		.devtbl_req_o  (devtbl_req),
		.scratch_req_o (scratch_req),
		.devtbl_rsp_i  (devtbl_rsp),
		.scratch_rsp_i (scratch_rsp)
	);

	dev_table_regs dev_table_regs_i (
		.clk120mhz (clk120mhz),
		.rst_p     (rst_p),
		.req_i     (devtbl_req),
		.rsp_o     (devtbl_rsp),
		.rst_ctl_o (rst_ctl)
	);

	scratch_ram scratch_ram_i (
		.clk120mhz (clk120mhz),
		.rst_p     (rst_p),
		.req_i     (scratch_req),
		.rsp_o     (scratch_rsp)
	);

	reset_sequencer reset_sequencer_i (
		.clk120mhz     (clk120mhz),
		.rst_p         (rst_p),
		.rst_ctl_i     (rst_ctl),
		.cpu_rst_req_i (cpu_rst_req_i),
		.sys_rst_o     (sys_rst_o),
		.coldrst_o     (coldrst_o),
		.pwroff_o      (pwroff_o)
	);

endmodule

//--- sim/tb_clock_gen.sv
// clock and reset source for the testbench
// 40 ns clock with reset held for the first 8 rising edges

`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk120mhz_o,
	output logic rst_p_o,
	input  logic rst_again_i
);

	logic init_rst;

	initial begin
		clk120mhz_o = 1'b0;
		forever #20 clk120mhz_o = ~clk120mhz_o;
	end

	initial begin
		init_rst = 1'b1;
		repeat (8) @(posedge clk120mhz_o);
		#2;
		init_rst = 1'b0;
	end

	// the testbench can pull reset again later in the run
	assign rst_p_o = init_rst || rst_again_i;

endmodule

//--- sim/sysctl_tb.sv
// testbench for the system-control top level
// checks reset release, runs a bus table against the slaves,
// then exercises the warm, cpu, cold and power-off reset paths

`timescale 1ns/1ps

module sysctl_tb;

	typedef struct packed {
		sysctl_pkg::pi1_op_e op;
		logic [31:0]         addr;
		logic [31:0]         wdata;
		logic [3:0]          sel;
		logic [31:0]         exp_data;
	} bus_row_t;

	logic                 clk120mhz;
	logic                 rst_p;
	logic                 rst_again;
	logic                 cpu_rst_req;
	logic                 sys_rst;
	logic                 coldrst;
	logic                 pwroff;
	sysctl_pkg::pi1_req_t m_req;
	sysctl_pkg::pi1_rsp_t m_rsp;

	bus_row_t    rows[$];
	string       row_names[$];
	// expected scratch contents for byte addresses 256 up to 1279
	logic [31:0] shadow_mem [256];
	logic [31:0] lcg_state = 32'ha189_ae3b;
	int          cycle_cnt = 0;
	int          cycle_limit = 0;

	tb_clock_gen tb_clock_gen_i (
		.clk120mhz_o (clk120mhz),
		.rst_p_o     (rst_p),
		.rst_again_i (rst_again)
	);

	sysctl_top sysctl_top_i (
		.clk120mhz     (clk120mhz),
		.rst_p         (rst_p),
		.m_req_i       (m_req),
		.m_rsp_o       (m_rsp),
		.cpu_rst_req_i (cpu_rst_req),
		.sys_rst_o     (sys_rst),
		.coldrst_o     (coldrst),
		.pwroff_o      (pwroff)
	);

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
		input logic [31:0] new_word, input logic [3:0] sel);
		logic [31:0] merged;
		merged = old_word;
		for (int lane = 0; lane < 4; lane++) begin
			if (sel[lane]) begin
				merged[8*lane +: 8] = new_word[8*lane +: 8];
			end
		end
		return merged;
	endfunction

	task automatic stop_on_error();
		$display("FAIL: see errors above");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		assert (act_val === exp_val) else begin
			$display("error: %s expected %0d actual %0d", name, exp_val, act_val);
			stop_on_error();
		end
	endtask

	// scratch rows track the shadow memory and other rows keep exp_in
	task automatic add_row(input string name, input sysctl_pkg::pi1_op_e op,
		input logic [31:0] addr, input logic [31:0] wdata, input logic [3:0] sel,
		input logic [31:0] exp_in);
		logic [31:0] exp_data;
		logic [31:0] word_off;
		exp_data = exp_in;
		word_off = (addr - 32'd256) >> 2;
		if (addr >= 32'd256 && addr < 32'd1280) begin
			if (op == sysctl_pkg::OP_WRITE) begin
				shadow_mem[word_off[7:0]] = merge_bytes(shadow_mem[word_off[7:0]], wdata, sel);
			end else begin
				exp_data = shadow_mem[word_off[7:0]];
			end
		end
		rows.push_back('{op: op, addr: addr, wdata: wdata, sel: sel, exp_data: exp_data});
		row_names.push_back(name);
	endtask

	task automatic build_table();
		logic [3:0] part_sel [4];
		part_sel = '{4'b0101, 4'b1000, 4'b0011, 4'b0110};
		add_row("devtbl soc id", sysctl_pkg::OP_READ, 0, 0, 4'hf, 1);
		add_row("devtbl slave count", sysctl_pkg::OP_READ, 4, 0, 4'hf, 3);
		add_row("devtbl id 0", sysctl_pkg::OP_READ, 8, 0, 4'hf, 7);
		add_row("devtbl size 0", sysctl_pkg::OP_READ, 12, 0, 4'hf, 256);
		add_row("devtbl id 1", sysctl_pkg::OP_READ, 16, 0, 4'hf, 1);
		add_row("devtbl size 1", sysctl_pkg::OP_READ, 20, 0, 4'hf, 1024);
		add_row("devtbl id 2", sysctl_pkg::OP_READ, 24, 0, 4'hf, 0);
		add_row("devtbl size 2", sysctl_pkg::OP_READ, 28, 0, 4'hf, 4096);
		add_row("devtbl past end", sysctl_pkg::OP_READ, 32, 0, 4'hf, 0);
		add_row("devtbl write size 0", sysctl_pkg::OP_WRITE, 12, 32'h5a5a_5a5a, 4'hf, 0);
		add_row("devtbl size 0 kept", sysctl_pkg::OP_READ, 12, 0, 4'hf, 256);
		for (int i = 0; i < 4; i++) begin
			add_row($sformatf("ram fill %0d", i), sysctl_pkg::OP_WRITE, 256 + 4*i,
				lcg_next(), 4'hf, 0);
		end
		for (int i = 0; i < 4; i++) begin
			add_row($sformatf("ram partial %0d", i), sysctl_pkg::OP_WRITE, 256 + 4*i,
				lcg_next(), part_sel[i], 0);
		end
		add_row("ram top fill", sysctl_pkg::OP_WRITE, 1276, lcg_next(), 4'hf, 0);
		for (int i = 0; i < 4; i++) begin
			add_row($sformatf("ram read %0d", i), sysctl_pkg::OP_READ, 256 + 4*i, 0, 4'hf, 0);
		end
		add_row("ram top read", sysctl_pkg::OP_READ, 1276, 0, 4'hf, 0);
		add_row("unmapped 1280", sysctl_pkg::OP_READ, 1280, 0, 4'hf, 0);
		add_row("unmapped 4096", sysctl_pkg::OP_READ, 4096, 0, 4'hf, 0);
		add_row("unmapped top", sysctl_pkg::OP_READ, 32'hffff_fffc, 0, 4'hf, 0);
		add_row("unmapped write", sysctl_pkg::OP_WRITE, 1280, 32'hdead_beef, 4'hf, 0);
		add_row("ram word 0 kept", sysctl_pkg::OP_READ, 256, 0, 4'hf, 0);
	endtask

	// holds the request until rdy is seen at a rising edge, then drops op
	task automatic bus_xfer(input sysctl_pkg::pi1_op_e op, input logic [31:0] addr,
		input logic [31:0] wdata, input logic [3:0] sel,
		output logic [31:0] rdata, output int waits);
		logic done;
		m_req = '{op: op, addr: addr[31:2], data: wdata, sel: sel};
		waits = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk120mhz);
			if (m_rsp.rdy) begin
				done = 1'b1;
			end else begin
				waits++;
				@(posedge clk120mhz);
				#2;
			end
		end
		rdata = m_rsp.data;
		@(posedge clk120mhz);
		#2;
		m_req.op = sysctl_pkg::OP_NOP;
	endtask

	// counts cycles of the first high run of sys_rst or of coldrst
	task automatic measure_high_run(input logic use_cold, output int len);
		int   idle;
		logic lvl;
		len = 0;
		idle = 0;
		@(negedge clk120mhz);
		lvl = use_cold ? coldrst : sys_rst;
		while (!lvl && idle < 6) begin
			idle++;
			@(negedge clk120mhz);
			lvl = use_cold ? coldrst : sys_rst;
		end
		while (lvl && len < 40) begin
			len++;
			@(negedge clk120mhz);
			lvl = use_cold ? coldrst : sys_rst;
		end
	endtask

	always @(posedge clk120mhz) begin
		cycle_cnt++;
		if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
			$display("timeout: run went past %0d cycles", cycle_limit);
			stop_on_error();
		end
	end

	initial begin
		int          waits;
		int          run_len;
		int          exp_waits;
		logic [31:0] rdata;
		m_req = '0;
		cpu_rst_req = 1'b0;
		rst_again = 1'b0;
		build_table();
		cycle_limit = rows.size() * 4 + 200;

		@(negedge clk120mhz);
		check_value("sys_rst during rst_p", 1, sys_rst);
		@(negedge rst_p);
		measure_high_run(1'b0, run_len);
		check_value("sys_rst hold after rst_p", 15, run_len);
		check_value("rdy after reset", 0, m_rsp.rdy);
		check_value("coldrst after reset", 0, coldrst);
		check_value("pwroff after reset", 0, pwroff);
		@(posedge clk120mhz);
		#2;

		foreach (rows[i]) begin
			bus_xfer(rows[i].op, rows[i].addr, rows[i].wdata, rows[i].sel, rdata, waits);
			// registered slaves answer a cycle later and the default region at once
			exp_waits = (rows[i].addr >= 32'd1280) ? 0 : 1;
			check_value({row_names[i], " rdy wait"}, exp_waits, waits);
			// no table row writes the reset-control word
			check_value({row_names[i], " sys_rst"}, 0, sys_rst);
			if (rows[i].op == sysctl_pkg::OP_READ) begin
				assert (rdata === rows[i].exp_data) else begin
					$display("error: %s expected %h actual %h", row_names[i],
						rows[i].exp_data, rdata);
					stop_on_error();
				end
			end
		end

		fork
			bus_xfer(sysctl_pkg::OP_WRITE, 32'd0, 32'd2, 4'hf, rdata, waits);
			measure_high_run(1'b0, run_len);
		join
		check_value("warm reset length", 16, run_len);
		@(posedge clk120mhz);
		#2;

		fork
			begin
				cpu_rst_req = 1'b1;
				@(posedge clk120mhz);
				#2;
				cpu_rst_req = 1'b0;
			end
			measure_high_run(1'b0, run_len);
		join
		check_value("cpu reset length", 16, run_len);
		@(posedge clk120mhz);
		#2;

		fork
			bus_xfer(sysctl_pkg::OP_WRITE, 32'd0, 32'd3, 4'hf, rdata, waits);
			measure_high_run(1'b1, run_len);
		join
		check_value("coldrst pulse length", 1, run_len);
		check_value("pwroff after cold request", 0, pwroff);
		@(posedge clk120mhz);
		#2;

		// power-off must hold sys_rst until rst_p comes back
		bus_xfer(sysctl_pkg::OP_WRITE, 32'd0, 32'd1, 4'hf, rdata, waits);
		repeat (20) begin
			@(negedge clk120mhz);
			assert (pwroff && sys_rst) else begin
				$display("power-off latch or its reset hold dropped before rst_p");
				stop_on_error();
			end
		end
		@(posedge clk120mhz);
		#2;
		rst_again = 1'b1;
		repeat (3) @(posedge clk120mhz);
		#2;
		rst_again = 1'b0;
		measure_high_run(1'b0, run_len);
		check_value("sys_rst hold after second rst_p", 15, run_len);
		check_value("pwroff after second rst_p", 0, pwroff);

		$display("PASS: all tests");
		$finish;
	end

endmodule

//--- filelist.f
hw/sysctl_pkg.sv
hw/pi1_addr_decoder.sv
hw/dev_table_regs.sv
hw/reset_sequencer.sv
hw/scratch_ram.sv
hw/sysctl_top.sv
sim/tb_clock_gen.sv
sim/sysctl_tb.sv

//--- Makefile
# Verilator build and run for the system-control testbench

VERILATOR ?= verilator
TOP       ?= sysctl_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= PASS: all tests
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
